// File: verilog/csr_pkg.sv
// ============================
// Shared widths, types and constants for the machine-mode CSR unit
// Imported by every RTL block and by the testbench
// ============================
package csr_pkg;

  // ============================
  // Widths and types
  // ============================
  localparam int XLEN = 32;                 // RV32 only

  typedef logic [XLEN-1:0] xlen_t;          // One register value
  typedef logic [11:0]     csr_addr_t;      // Architectural CSR address
  typedef logic [13:0]     paddr_t;         // [13:12] alias op, [11:0] CSR

  // Operation picked by the APB address alias bits
  typedef enum logic [1:0] {
    OP_WRITE = 2'b00,                       // Replace
    OP_SET   = 2'b01,                       // OR in wdata
    OP_CLEAR = 2'b10                        // AND with ~wdata
  } csr_op_t;

  typedef logic [1:0] priv_t;
  localparam priv_t PRIV_U = 2'b00;
  localparam priv_t PRIV_S = 2'b01;         // Reserved, no S-mode here
  localparam priv_t PRIV_M = 2'b11;

  typedef logic [4:0] cause_t;              // Exception code, no interrupt bit
  typedef logic [4:0] fflags_t;             // NV DZ OF UF NX
  typedef logic [2:0] frm_t;                // Rounding mode

  // ============================
  // CSR addresses
  // ============================
  // Machine trap setup
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;

  // Machine trap handling
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MIP       = 12'h344;

  // Machine identity, read-only range
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // Floating point, user level
  localparam csr_addr_t CSR_FFLAGS    = 12'h001;
  localparam csr_addr_t CSR_FRM       = 12'h002;
  localparam csr_addr_t CSR_FCSR      = 12'h003;  // frm and fflags together

  // ============================
  // Field positions and constants
  // ============================
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;     // MPP is [12:11]

  localparam xlen_t MISA_VALUE   = 32'h4000_0100;  // MXL=1, I base
  localparam xlen_t MIMPID_VALUE = 32'd1;
  localparam priv_t MPP_RESET    = PRIV_M;

endpackage

// File: verilog/csr_apb_port.sv
// ============================
// APB slave front end of the CSR unit
// Runs the read-modify-write of each access, no wait states
// Old value goes back on prdata, pslverr flags illegal accesses
// ============================
`timescale 1ns/1ps

module csr_apb_port (
  input  logic               clk,
  input  logic               reset_n,
  // APB slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  csr_pkg::paddr_t    paddr,
  input  csr_pkg::xlen_t     pwdata,
  output logic               pready,
  output csr_pkg::xlen_t     prdata,
  output logic               pslverr,
  // Checker
  input  logic               illegal,
  output csr_pkg::csr_addr_t rd_addr,
  output logic               access_write,
  // Register blocks
  input  csr_pkg::xlen_t     mtrap_rdata,
  input  csr_pkg::xlen_t     fp_rdata,
  output logic               wr_en,
  output csr_pkg::csr_addr_t wr_addr,
  output csr_pkg::xlen_t     wr_data
);
  import csr_pkg::*;

  logic    setup_q;      // Last cycle was a setup phase
  logic    access;       // Access phase of a proper transfer
  csr_op_t op;
  xlen_t   old_value;    // CSR contents before this access
  xlen_t   new_value;

  // ============================
  // Phase tracking
  // ============================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel & ~penable;
    end
  end

  assign access = psel & penable & setup_q;

  // Address split, alias bits only matter for writes
  assign op           = csr_op_t'(paddr[13:12]);
  assign rd_addr      = paddr[11:0];
  assign access_write = pwrite;

  // Blocks return zero for addresses they don't own
  assign old_value = mtrap_rdata | fp_rdata;

  always_comb begin
    case (op)
      OP_WRITE: new_value = pwdata;
      OP_SET:   new_value = old_value | pwdata;
      OP_CLEAR: new_value = old_value & ~pwdata;
      default:  new_value = old_value;      // Unused alias, leave as is
    endcase
  end

  // Commit at the edge closing the access phase
  assign wr_en   = access & pwrite & ~illegal;
  assign wr_addr = rd_addr;
  assign wr_data = new_value;

  // APB response
  assign pready  = access;                  // Never stretched
  assign prdata  = access ? old_value : '0;
  assign pslverr = access & illegal;

  // Master must go through a setup phase first
  a_penable_after_psel: assert property (
    @(posedge clk) disable iff (!reset_n)
    $rose(penable) |-> $past(psel)
  );

endmodule

// File: verilog/csr_access_check.sv
// ============================
// Combinational legality check for one CSR access
// Looks at existence, privilege level and read-only encoding
// ============================
`timescale 1ns/1ps

module csr_access_check (
  input  csr_pkg::csr_addr_t rd_addr,
  input  logic               access_write,   // High for a write access
  input  csr_pkg::priv_t     priv,           // Current hart privilege
  output logic               illegal
);
  import csr_pkg::*;

  logic  exists;
  logic  priv_ok;
  logic  read_only;
  priv_t csr_priv;

  // Implemented set
  always_comb begin
    case (rd_addr)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP:
        exists = 1'b1;
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID:
        exists = 1'b1;
      CSR_FFLAGS, CSR_FRM, CSR_FCSR:
        exists = 1'b1;
      default:
        exists = 1'b0;
    endcase
  end

  // Minimum privilege sits in address bits [9:8]
  assign csr_priv = rd_addr[9:8];
  assign priv_ok  = (priv >= csr_priv);

  // Top two bits set means read-only, misa is read-only here too
  assign read_only = (rd_addr[11:10] == 2'b11) || (rd_addr == CSR_MISA);

  // Reads skip the read-only test
  assign illegal = !exists || !priv_ok || (access_write && read_only);

endmodule

// File: verilog/csr_machine_trap.sv
// ============================
// Machine status and trap registers plus the identity CSRs
// Handles trap entry and MRET from the core side band
// Read data is zero for any address not owned here
// ============================
`timescale 1ns/1ps

module csr_machine_trap (
  input  logic               clk,
  input  logic               reset_n,
  // CSR access
  input  csr_pkg::csr_addr_t rd_addr,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t wr_addr,
  input  csr_pkg::xlen_t     wr_data,
  output csr_pkg::xlen_t     rdata,
  // Core side band
  input  csr_pkg::priv_t     priv,
  input  logic               trap_entry,
  input  csr_pkg::xlen_t     trap_pc,
  input  csr_pkg::cause_t    trap_cause,
  input  csr_pkg::xlen_t     trap_val,
  input  logic               mret,
  output csr_pkg::xlen_t     trap_vector,
  output csr_pkg::xlen_t     mepc_out,
  output logic               mstatus_mie,
  output csr_pkg::priv_t     mpp_out
);
  import csr_pkg::*;

  // ============================
  // State
  // ============================
  logic  status_mie_q;       // mstatus.MIE
  logic  status_mpie_q;      // mstatus.MPIE
  priv_t status_mpp_q;       // mstatus.MPP
  xlen_t mie_q;              // Interrupt enables, no sources yet
  xlen_t mtvec_q;            // Direct mode only
  xlen_t mscratch_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mtval_q;
  xlen_t mip_q;
  xlen_t mstatus_val;        // Assembled view

  // Only MIE, MPIE and MPP are live, rest reads zero
  always_comb begin
    mstatus_val                            = '0;
    mstatus_val[MSTATUS_MIE_BIT]           = status_mie_q;
    mstatus_val[MSTATUS_MPIE_BIT]          = status_mpie_q;
    mstatus_val[MSTATUS_MPP_LSB +: 2]      = status_mpp_q;
  end

  // ============================
  // Read mux
  // ============================
  always_comb begin
    case (rd_addr)
      CSR_MSTATUS:   rdata = mstatus_val;
      CSR_MISA:      rdata = MISA_VALUE;
      CSR_MIE:       rdata = mie_q;
      CSR_MTVEC:     rdata = mtvec_q;
      CSR_MSCRATCH:  rdata = mscratch_q;
      CSR_MEPC:      rdata = mepc_q;
      CSR_MCAUSE:    rdata = mcause_q;
      CSR_MTVAL:     rdata = mtval_q;
      CSR_MIP:       rdata = mip_q;
      CSR_MVENDORID: rdata = '0;            // Non-commercial
      CSR_MARCHID:   rdata = '0;
      CSR_MIMPID:    rdata = MIMPID_VALUE;
      CSR_MHARTID:   rdata = '0;            // Single hart
      default:       rdata = '0;            // Not ours
    endcase
  end

  // ============================
  // Update
  // ============================
  // Priority: trap entry, then MRET, then CSR write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      status_mie_q  <= 1'b0;
      status_mpie_q <= 1'b0;
      status_mpp_q  <= MPP_RESET;
      mie_q         <= '0;
      mtvec_q       <= '0;
      mscratch_q    <= '0;
      mepc_q        <= '0;
      mcause_q      <= '0;
      mtval_q       <= '0;
      mip_q         <= '0;
    end else if (trap_entry) begin
      mepc_q        <= trap_pc;
      mcause_q      <= {{(XLEN-$bits(cause_t)){1'b0}}, trap_cause};
      mtval_q       <= trap_val;
      status_mpie_q <= status_mie_q;        // Stash enable
      status_mie_q  <= 1'b0;                // Mask in handler
      status_mpp_q  <= priv;                // Where we came from
    end else if (mret) begin
      status_mie_q  <= status_mpie_q;
      status_mpie_q <= 1'b1;
      status_mpp_q  <= PRIV_M;
    end else if (wr_en) begin
      case (wr_addr)
        CSR_MSTATUS: begin
          status_mie_q  <= wr_data[MSTATUS_MIE_BIT];
          status_mpie_q <= wr_data[MSTATUS_MPIE_BIT];
          status_mpp_q  <= wr_data[MSTATUS_MPP_LSB +: 2];
        end
        CSR_MIE:      mie_q      <= wr_data;
        CSR_MTVEC:    mtvec_q    <= {wr_data[XLEN-1:2], 2'b00};  // Word aligned
        CSR_MSCRATCH: mscratch_q <= wr_data;
        CSR_MEPC:     mepc_q     <= {wr_data[XLEN-1:2], 2'b00};  // Word aligned
        CSR_MCAUSE:   mcause_q   <= wr_data;
        CSR_MTVAL:    mtval_q    <= wr_data;
        CSR_MIP:      mip_q      <= wr_data;
        default: ;                          // FP or read-only
      endcase
    end
  end

  // Side band outputs
  assign trap_vector = mtvec_q;
  assign mepc_out    = mepc_q;
  assign mstatus_mie = status_mie_q;
  assign mpp_out     = status_mpp_q;

  // Core retires at most one of these per cycle
  a_no_trap_and_mret: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(trap_entry && mret)
  );

endmodule

// File: verilog/csr_fp_state.sv
// ============================
// Floating-point CSRs fflags, frm and fcsr
// Sticky flag accumulation from the FPU, forwarded to reads
// ============================
`timescale 1ns/1ps

module csr_fp_state (
  input  logic               clk,
  input  logic               reset_n,
  // CSR access
  input  csr_pkg::csr_addr_t rd_addr,
  input  logic               wr_en,
  input  csr_pkg::csr_addr_t wr_addr,
  input  csr_pkg::xlen_t     wr_data,
  output csr_pkg::xlen_t     rdata,
  // FPU side band
  input  logic               fflags_we,
  input  csr_pkg::fflags_t   fflags_in,
  output csr_pkg::frm_t      frm_out,
  output csr_pkg::fflags_t   fflags_out
);
  import csr_pkg::*;

  frm_t    frm_q;
  fflags_t fflags_q;
  fflags_t fflags_fwd;    // Flags including this cycle's FPU result
  logic    flags_write;   // CSR write hits fflags this cycle

  assign fflags_fwd  = fflags_we ? (fflags_q | fflags_in) : fflags_q;
  assign flags_write = wr_en && (wr_addr == CSR_FFLAGS || wr_addr == CSR_FCSR);

  // fcsr layout: frm [7:5], fflags [4:0]
  always_comb begin
    case (rd_addr)
      CSR_FFLAGS: rdata = {{(XLEN-5){1'b0}}, fflags_fwd};
      CSR_FRM:    rdata = {{(XLEN-3){1'b0}}, frm_q};
      CSR_FCSR:   rdata = {{(XLEN-8){1'b0}}, frm_q, fflags_fwd};
      default:    rdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      frm_q <= '0;                          // RNE
    end else if (wr_en && (wr_addr == CSR_FRM)) begin
      frm_q <= wr_data[2:0];
    end else if (wr_en && (wr_addr == CSR_FCSR)) begin
      frm_q <= wr_data[7:5];
    end
  end

  // CSR write beats accumulation
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags_q <= '0;
    end else if (flags_write) begin
      fflags_q <= wr_data[4:0];
    end else if (fflags_we) begin
      fflags_q <= fflags_fwd;               // Sticky OR
    end
  end

  assign frm_out    = frm_q;
  assign fflags_out = fflags_q;

endmodule

// File: verilog/csr_unit.sv
// ============================
// CSR unit top level
// APB port, access checker, machine trap block and FP block
// ============================
`timescale 1ns/1ps

module csr_unit (
  input  logic               clk,
  input  logic               reset_n,
  // APB slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  csr_pkg::paddr_t    paddr,
  input  csr_pkg::xlen_t     pwdata,
  output logic               pready,
  output csr_pkg::xlen_t     prdata,
  output logic               pslverr,
  // Core side band
  input  csr_pkg::priv_t     priv,
  input  logic               trap_entry,
  input  csr_pkg::xlen_t     trap_pc,
  input  csr_pkg::cause_t    trap_cause,
  input  csr_pkg::xlen_t     trap_val,
  input  logic               mret,
  output csr_pkg::xlen_t     trap_vector,
  output csr_pkg::xlen_t     mepc_out,
  output logic               mstatus_mie,
  output csr_pkg::priv_t     mpp_out,
  // FPU side band
  input  logic               fflags_we,
  input  csr_pkg::fflags_t   fflags_in,
  output csr_pkg::frm_t      frm_out,
  output csr_pkg::fflags_t   fflags_out
);
  import csr_pkg::*;

  csr_addr_t rd_addr;
  csr_addr_t wr_addr;
  xlen_t     wr_data;
  xlen_t     mtrap_rdata;
  xlen_t     fp_rdata;
  logic      access_write;
  logic      wr_en;
  logic      illegal;

  csr_apb_port u_port (
    .clk          (clk),
    .reset_n      (reset_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pready       (pready),
    .prdata       (prdata),
    .pslverr      (pslverr),
    .illegal      (illegal),
    .rd_addr      (rd_addr),
    .access_write (access_write),
    .mtrap_rdata  (mtrap_rdata),
    .fp_rdata     (fp_rdata),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  csr_access_check u_check (
    .rd_addr      (rd_addr),
    .access_write (access_write),
    .priv         (priv),
    .illegal      (illegal)
  );

  csr_machine_trap u_mtrap (
    .clk         (clk),
    .reset_n     (reset_n),
    .rd_addr     (rd_addr),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rdata       (mtrap_rdata),
    .priv        (priv),
    .trap_entry  (trap_entry),
    .trap_pc     (trap_pc),
    .trap_cause  (trap_cause),
    .trap_val    (trap_val),
    .mret        (mret),
    .trap_vector (trap_vector),
    .mepc_out    (mepc_out),
    .mstatus_mie (mstatus_mie),
    .mpp_out     (mpp_out)
  );

  csr_fp_state u_fp (
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_addr    (rd_addr),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rdata      (fp_rdata),
    .fflags_we  (fflags_we),
    .fflags_in  (fflags_in),
    .frm_out    (frm_out),
    .fflags_out (fflags_out)
  );

endmodule

// File: bench/tb_csr_tasks.svh
// ============================
// APB driver, compare tasks and directed tests
// Included inside the testbench top and uses its signals directly
// ============================
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// ============================
// Compare tasks
// ============================
task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_fflags(input string what, input fflags_t got, input fflags_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_priv(input string what, input priv_t got, input priv_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    stop_on_failure();
  end
endtask

// ============================
// APB driver
// ============================
// One setup plus access transfer with an optional FPU pulse in the access phase
task automatic apb_access(input logic write, input csr_op_t op, input csr_addr_t addr,
                          input xlen_t wdata, input logic fpu_en, input fflags_t fpu_flags,
                          output xlen_t rdata, output logic err);
  int cycles;
  cycles  = 0;
  @(negedge clk);
  psel    = 1'b1;                     // Setup phase
  penable = 1'b0;
  pwrite  = write;
  paddr   = {op, addr};
  pwdata  = wdata;
  @(negedge clk);
  penable = 1'b1;                     // Access phase
  if (fpu_en) begin
    fflags_we = 1'b1;
    fflags_in = fpu_flags;
  end
  #SAMPLE_DELAY;
  while (!pready) begin
    if (cycles >= APB_TIMEOUT) begin
      $display("Timeout: pready never came during the APB access phase");
      stop_on_failure();
    end
    @(negedge clk);
    #SAMPLE_DELAY;
    cycles++;
  end
  rdata = prdata;
  err   = pslverr;
  @(negedge clk);                     // Commit edge has passed
  psel      = 1'b0;
  penable   = 1'b0;
  pwrite    = 1'b0;
  fflags_we = 1'b0;
endtask

// Legal access that must return exp_old
task automatic csr_write(input csr_op_t op, input csr_addr_t addr, input xlen_t data,
                         input xlen_t exp_old);
  xlen_t rd;
  logic  err;
  apb_access(1'b1, op, addr, data, 1'b0, '0, rd, err);
  check_flag("pslverr on write", err, 1'b0);
  check_xlen("old value on write", rd, exp_old);
endtask

task automatic read_expect(input string what, input csr_addr_t addr, input xlen_t exp);
  xlen_t rd;
  logic  err;
  apb_access(1'b0, OP_WRITE, addr, '0, 1'b0, '0, rd, err);
  check_flag("pslverr on read", err, 1'b0);
  check_xlen(what, rd, exp);
endtask

task automatic expect_illegal(input logic write, input csr_addr_t addr, input xlen_t data);
  xlen_t rd;
  logic  err;
  apb_access(write, OP_WRITE, addr, data, 1'b0, '0, rd, err);
  check_flag("pslverr on illegal access", err, 1'b1);
endtask

// ============================
// Directed tests
// ============================
task automatic verify_reset_values();
  read_expect("mstatus after reset", CSR_MSTATUS, 32'h0000_1800);  // MPP = M
  read_expect("misa", CSR_MISA, MISA_VALUE);
  read_expect("mimpid", CSR_MIMPID, MIMPID_VALUE);
  read_expect("frm after reset", CSR_FRM, '0);
  check_xlen("trap_vector after reset", trap_vector, '0);
  check_flag("mstatus_mie after reset", mstatus_mie, 1'b0);
  check_priv("mpp_out after reset", mpp_out, PRIV_M);
  check_fflags("fflags_out after reset", fflags_out, '0);
endtask

task automatic exercise_rmw_ops();
  xlen_t a;
  xlen_t b;
  xlen_t c;
  xlen_t d;
  a = rand_word();
  b = rand_word();
  c = rand_word();
  d = rand_word();
  csr_write(OP_WRITE, CSR_MSCRATCH, a, mscratch_model);
  mscratch_model = a;
  csr_write(OP_SET, CSR_MSCRATCH, b, mscratch_model);
  mscratch_model = mscratch_model | b;
  csr_write(OP_CLEAR, CSR_MSCRATCH, c, mscratch_model);
  mscratch_model = mscratch_model & ~c;
  read_expect("mscratch after clear", CSR_MSCRATCH, mscratch_model);
  // mtvec drops the low two bits
  csr_write(OP_WRITE, CSR_MTVEC, d, '0);
  read_expect("mtvec", CSR_MTVEC, {d[31:2], 2'b00});
  check_xlen("trap_vector", trap_vector, {d[31:2], 2'b00});
endtask

task automatic reject_illegal_accesses();
  expect_illegal(1'b0, 12'h7C0, '0);              // Not implemented
  expect_illegal(1'b1, CSR_MISA, rand_word());
  read_expect("misa after illegal write", CSR_MISA, MISA_VALUE);
  priv = PRIV_U;
  expect_illegal(1'b1, CSR_MSCRATCH, rand_word());
  expect_illegal(1'b0, CSR_MSCRATCH, '0);
  read_expect("fflags from user mode", CSR_FFLAGS, '0);  // User level CSR
  priv = PRIV_M;
  read_expect("mscratch unchanged", CSR_MSCRATCH, mscratch_model);
endtask

task automatic take_trap_and_mret();
  xlen_t  pc;
  xlen_t  val;
  cause_t cause;
  pc    = rand_word();
  val   = rand_word();
  cause = cause_t'(rand_word());
  csr_write(OP_SET, CSR_MSTATUS, 32'h0000_0008, 32'h0000_1800);
  check_flag("mstatus_mie after set", mstatus_mie, 1'b1);
  // One cycle trap pulse from user mode
  priv       = PRIV_U;
  trap_entry = 1'b1;
  trap_pc    = pc;
  trap_cause = cause;
  trap_val   = val;
  @(negedge clk);
  trap_entry = 1'b0;
  priv       = PRIV_M;
  read_expect("mepc", CSR_MEPC, pc);
  check_xlen("mepc_out", mepc_out, pc);
  read_expect("mcause", CSR_MCAUSE, {27'b0, cause});
  read_expect("mtval", CSR_MTVAL, val);
  read_expect("mstatus after trap", CSR_MSTATUS, 32'h0000_0080);  // MPIE only
  check_flag("mstatus_mie after trap", mstatus_mie, 1'b0);
  check_priv("mpp_out after trap", mpp_out, PRIV_U);
  mret = 1'b1;
  @(negedge clk);
  mret = 1'b0;
  read_expect("mstatus after mret", CSR_MSTATUS, 32'h0000_1888);
  check_flag("mstatus_mie after mret", mstatus_mie, 1'b1);
  check_priv("mpp_out after mret", mpp_out, PRIV_M);
endtask

task automatic accumulate_fp_flags();
  fflags_t f1;
  fflags_t f2;
  fflags_t f3;
  fflags_t f4;
  fflags_t acc;
  xlen_t   w;
  xlen_t   rd;
  logic    err;
  f1 = fflags_t'(rand_word());
  f2 = fflags_t'(rand_word());
  f3 = fflags_t'(rand_word());
  w  = rand_word() & 32'hFE;          // Bit 0 of fflags written as zero
  f4 = ~w[4:0] | 5'b00001;            // Set bits the write must drop
  // Two sticky FPU pulses
  fflags_we = 1'b1;
  fflags_in = f1;
  @(negedge clk);
  fflags_in = f2;
  @(negedge clk);
  fflags_we = 1'b0;
  acc = f1 | f2;
  check_fflags("fflags_out after two pulses", fflags_out, acc);
  read_expect("fflags after two pulses", CSR_FFLAGS, {27'b0, acc});
  // Read sees flags arriving in the same cycle
  apb_access(1'b0, OP_WRITE, CSR_FFLAGS, '0, 1'b1, f3, rd, err);
  acc = acc | f3;
  check_flag("pslverr on forwarded read", err, 1'b0);
  check_xlen("forwarded fflags read", rd, {27'b0, acc});
  check_fflags("fflags_out after forwarded read", fflags_out, acc);
  // fcsr write wins over accumulation
  apb_access(1'b1, OP_WRITE, CSR_FCSR, w, 1'b1, f4, rd, err);
  check_flag("pslverr on fcsr write", err, 1'b0);
  check_xlen("old fcsr", rd, {24'b0, 3'b000, acc | f4});
  check_fflags("fflags_out after fcsr write", fflags_out, w[4:0]);
  read_expect("fcsr after write", CSR_FCSR, {24'b0, w[7:0]});
  read_expect("frm after fcsr write", CSR_FRM, {29'b0, w[7:5]});
  check_xlen("frm_out", {29'b0, frm_out}, {29'b0, w[7:5]});
endtask

`endif

// File: bench/tb_csr_unit.sv
// ============================
// Testbench top for the CSR unit
// Clock, reset, DUT and random source, then the directed tests in turn
// Inputs change on the falling edge, outputs are sampled mid low phase
// ============================
`timescale 1ns/1ps

module tb_csr_unit;
  import csr_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int SAMPLE_DELAY = 5;    // Quarter period after the falling edge
  localparam int APB_TIMEOUT  = 16;   // Cycles allowed for pready

  logic     clk;
  logic     reset_n;
  // APB master side
  logic     psel;
  logic     penable;
  logic     pwrite;
  paddr_t   paddr;
  xlen_t    pwdata;
  logic     pready;
  xlen_t    prdata;
  logic     pslverr;
  // Core side band
  priv_t    priv;
  logic     trap_entry;
  xlen_t    trap_pc;
  cause_t   trap_cause;
  xlen_t    trap_val;
  logic     mret;
  xlen_t    trap_vector;
  xlen_t    mepc_out;
  logic     mstatus_mie;
  priv_t    mpp_out;
  // FPU side band
  logic     fflags_we;
  fflags_t  fflags_in;
  frm_t     frm_out;
  fflags_t  fflags_out;

  xlen_t    rng_state;
  xlen_t    mscratch_model;           // Expected mscratch contents

  csr_unit u_dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pready      (pready),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .priv        (priv),
    .trap_entry  (trap_entry),
    .trap_pc     (trap_pc),
    .trap_cause  (trap_cause),
    .trap_val    (trap_val),
    .mret        (mret),
    .trap_vector (trap_vector),
    .mepc_out    (mepc_out),
    .mstatus_mie (mstatus_mie),
    .mpp_out     (mpp_out),
    .fflags_we   (fflags_we),
    .fflags_in   (fflags_in),
    .frm_out     (frm_out),
    .fflags_out  (fflags_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ============================
  // Random source and failure exit
  // ============================
  function automatic xlen_t xorshift32(input xlen_t s);
    xlen_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic xlen_t rand_word();
    rng_state = xorshift32(rng_state);    // Advance the shared state
    return rng_state;
  endfunction

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  `include "tb_csr_tasks.svh"

  initial begin
    reset_n        = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    priv           = PRIV_M;
    trap_entry     = 1'b0;
    trap_pc        = '0;
    trap_cause     = '0;
    trap_val       = '0;
    mret           = 1'b0;
    fflags_we      = 1'b0;
    fflags_in      = '0;
    rng_state      = 32'hd447c874;
    mscratch_model = '0;              // Scratch resets to zero

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    verify_reset_values();
    exercise_rmw_ops();
    reject_illegal_accesses();
    take_trap_and_mret();
    accumulate_fp_flags();

    $display("Everything OK");
    $finish;
  end

endmodule

// File: compile.f
+incdir+bench
verilog/csr_pkg.sv
verilog/csr_apb_port.sv
verilog/csr_access_check.sv
verilog/csr_machine_trap.sv
verilog/csr_fp_state.sv
verilog/csr_unit.sv
bench/tb_csr_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_csr_unit
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

SOURCES   = $(wildcard verilog/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is read back from the log
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
